//--- src/lane_cfg.svh
`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// Frame geometry, kept small so a whole frame simulates quickly
`define LANE_WIDTH  16
`define LANE_HEIGHT 12

// Depths of the input pixel queue and the crop queue
`define LANE_IN_FIFO_DEPTH   8
`define LANE_CROP_FIFO_DEPTH 8

// Window bounds loaded at reset cover the whole frame
// Bounds are inclusive on both ends
`define LANE_DEF_START_X 0
`define LANE_DEF_END_X   (`LANE_WIDTH - 1)
`define LANE_DEF_START_Y 0
`define LANE_DEF_END_Y   (`LANE_HEIGHT - 1)

`endif

//--- src/lane_pkg.sv
`default_nettype none

`include "lane_cfg.svh"

package lane_pkg;

    // One raw RGB pixel, 8 bits per channel, red in the top byte
    typedef logic [23:0] pixel_t;

    // Column and row indices sized to the configured frame
    typedef logic [$clog2(`LANE_WIDTH)-1:0]  coord_x_t;
    typedef logic [$clog2(`LANE_HEIGHT)-1:0] coord_y_t;

    // Linear frame buffer address, row times width plus column
    typedef logic [$clog2(`LANE_WIDTH * `LANE_HEIGHT)-1:0] frame_addr_t;

    // Wishbone word address into the register block
    typedef logic [2:0] reg_addr_t;

    // The loader either waits for a frame or scans one
    typedef enum logic {
        IDLE,
        SCAN
    } loader_state_t;

endpackage

`default_nettype wire

//--- src/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Synchronous show-ahead FIFO for pixels
// The word at the read pointer is always on dout, so the consumer can look
// at a pixel before deciding to pop it
module pixel_fifo #(
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  lane_pkg::pixel_t din,
    output logic             full,
    input  logic             rd_en,
    output lane_pkg::pixel_t dout,
    output logic             empty
);
    import lane_pkg::*;

    // A depth of one still needs a one bit pointer
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // The count has to reach DEPTH itself
    localparam int CNT_W = $clog2(DEPTH + 1);

    pixel_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // Occupancy alone decides full and empty
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Requests against a full or empty queue are dropped here
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Show-ahead output straight from the storage array
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly so any depth works
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A push and a pop in the same cycle leave the count unchanged
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The producer is expected to watch full before writing
    assert property (@(posedge clock) disable iff (reset) wr_en |-> !full)
        else $error("pixel_fifo: write while full");

    // The consumer is expected to watch empty before popping
    assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty)
        else $error("pixel_fifo: read while empty");

endmodule

`default_nettype wire

//--- src/image_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_cfg.svh"

// Raster-scan image loader
// Every pixel of a frame is written to the frame buffer, and the ones that
// fall inside the region of interest are also pushed into the crop queue
// that feeds the edge-detection pipeline
module image_loader (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  in_rd_en,
    input  logic                  in_empty,
    input  lane_pkg::pixel_t      in_dout,
    output logic                  crop_wr_en,
    input  logic                  crop_full,
    output lane_pkg::pixel_t      crop_din,
    output logic                  fb_wr_en,
    output lane_pkg::frame_addr_t fb_wr_addr,
    output lane_pkg::pixel_t      fb_wr_data,
    input  lane_pkg::coord_x_t    start_x,
    input  lane_pkg::coord_x_t    end_x,
    input  lane_pkg::coord_y_t    start_y,
    input  lane_pkg::coord_y_t    end_y,
    output logic                  busy,
    output logic                  frame_done
);
    import lane_pkg::*;

    localparam coord_x_t LAST_X = coord_x_t'(`LANE_WIDTH - 1);
    localparam coord_y_t LAST_Y = coord_y_t'(`LANE_HEIGHT - 1);

    loader_state_t state;
    loader_state_t next_state;
    coord_x_t      x;
    coord_x_t      x_c;
    coord_y_t      y;
    coord_y_t      y_c;
    frame_addr_t   addr;
    frame_addr_t   addr_c;
    coord_x_t      win_start_x;
    coord_x_t      win_end_x;
    coord_y_t      win_start_y;
    coord_y_t      win_end_y;
    logic          take;
    logic          in_window;
    logic          last_pixel;
    logic          frame_start;

    // A frame begins as soon as a pixel shows up while idle
    assign frame_start = (state == IDLE) && !in_empty;

    // One pixel moves per cycle when there is input and room downstream
    // A full crop queue stalls the frame buffer writes as well
    assign take = (state == SCAN) && !in_empty && !crop_full;

    // Inclusive window test against the bounds captured at frame start
    assign in_window = (x >= win_start_x) && (x <= win_end_x) &&
                       (y >= win_start_y) && (y <= win_end_y);

    assign last_pixel = (x == LAST_X) && (y == LAST_Y);

    // Both outputs carry the head of the input queue
    assign in_rd_en   = take;
    assign fb_wr_en   = take;
    assign fb_wr_addr = addr;
    assign fb_wr_data = in_dout;
    assign crop_wr_en = take && in_window;
    assign crop_din   = in_dout;

    assign busy       = (state == SCAN);
    assign frame_done = take && last_pixel;

    always_comb begin
        next_state = state;
        x_c        = x;
        y_c        = y;
        addr_c     = addr;
        case (state)
            IDLE: begin
                // Counters restart from the top left corner
                if (!in_empty) begin
                    next_state = SCAN;
                    x_c        = '0;
                    y_c        = '0;
                    addr_c     = '0;
                end
            end
            SCAN: begin
                if (take) begin
                    // The address runs alongside the counters, so no multiply
                    addr_c = addr + 1'b1;
                    if (x == LAST_X) begin
                        x_c = '0;
                        if (y == LAST_Y) begin
                            next_state = IDLE;
                        end else begin
                            y_c = y + 1'b1;
                        end
                    end else begin
                        x_c = x + 1'b1;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            x           <= '0;
            y           <= '0;
            addr        <= '0;
            win_start_x <= '0;
            win_end_x   <= '0;
            win_start_y <= '0;
            win_end_y   <= '0;
        end else begin
            state <= next_state;
            x     <= x_c;
            y     <= y_c;
            addr  <= addr_c;
            // Register writes during a frame only reach the next one
            if (frame_start) begin
                win_start_x <= start_x;
                win_end_x   <= end_x;
                win_start_y <= start_y;
                win_end_y   <= end_y;
            end
        end
    end

    // The running address must match row times width plus column
    assert property (@(posedge clock) disable iff (reset)
                     fb_wr_en |-> fb_wr_addr == frame_addr_t'(y * `LANE_WIDTH + x))
        else $error("image_loader: frame buffer address out of step with the counters");

    // The last pixel of a frame lands in the last word of the buffer
    assert property (@(posedge clock) disable iff (reset)
                     frame_done |->
                     fb_wr_addr == frame_addr_t'(`LANE_WIDTH * `LANE_HEIGHT - 1))
        else $error("image_loader: frame ended away from the last buffer word");

endmodule

`default_nettype wire

//--- src/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_cfg.svh"

// Full-frame pixel memory with one write port and one read port
// The read is registered so the array maps onto block RAM
module frame_buffer (
    input  logic                  clock,
    input  logic                  wr_en,
    input  lane_pkg::frame_addr_t wr_addr,
    input  lane_pkg::pixel_t      wr_data,
    input  lane_pkg::frame_addr_t rd_addr,
    output lane_pkg::pixel_t      rd_data
);
    import lane_pkg::*;

    localparam int WORDS = `LANE_WIDTH * `LANE_HEIGHT;

    pixel_t mem [WORDS];

    // Write port used by the loader
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port used by the overlay stage
    // Data for an address appears one clock after it is applied
    // A word written on the same edge is seen from the next address cycle on
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/roi_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_cfg.svh"

// Wishbone classic register block for the region of interest
// Word map
//   0 start_x, 1 end_x, 2 start_y, 3 end_y (read/write)
//   4 frame_count, 5 busy in bit 0 (read only)
module roi_regs (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  lane_pkg::reg_addr_t  wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    output lane_pkg::coord_x_t   start_x,
    output lane_pkg::coord_x_t   end_x,
    output lane_pkg::coord_y_t   start_y,
    output lane_pkg::coord_y_t   end_y,
    input  logic                 busy,
    input  logic                 frame_done
);
    import lane_pkg::*;

    localparam int XW = $bits(coord_x_t);
    localparam int YW = $bits(coord_y_t);

    logic [15:0] frame_count;
    logic        req;
    logic [31:0] rd_mux;

    // A new request is one not already being acknowledged
    // This keeps ack to a single cycle while the master still holds stb
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Readback of all registers, zero extended to the bus width
    always_comb begin
        case (wb_adr)
            3'd0:    rd_mux = 32'(start_x);
            3'd1:    rd_mux = 32'(end_x);
            3'd2:    rd_mux = 32'(start_y);
            3'd3:    rd_mux = 32'(end_y);
            3'd4:    rd_mux = 32'(frame_count);
            3'd5:    rd_mux = {31'b0, busy};
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            start_x     <= coord_x_t'(`LANE_DEF_START_X);
            end_x       <= coord_x_t'(`LANE_DEF_END_X);
            start_y     <= coord_y_t'(`LANE_DEF_START_Y);
            end_y       <= coord_y_t'(`LANE_DEF_END_Y);
            frame_count <= '0;
        end else begin
            wb_ack <= req;
            // Writes land on the edge that raises ack
            // Addresses 4 and up are read only and ignore writes
            if (req && wb_we) begin
                case (wb_adr)
                    3'd0:    start_x <= wb_dat_w[XW-1:0];
                    3'd1:    end_x   <= wb_dat_w[XW-1:0];
                    3'd2:    start_y <= wb_dat_w[YW-1:0];
                    3'd3:    end_y   <= wb_dat_w[YW-1:0];
                    default: ;
                endcase
            end
            // Counts completed frames and wraps at 16 bits
            if (frame_done) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // Read data is captured with the ack so both are valid together
    always_ff @(posedge clock) begin
        if (req) begin
            wb_dat_r <= rd_mux;
        end
    end

    // A strobe from the master is only valid inside a bus cycle
    assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("roi_regs: strobe outside a bus cycle");

endmodule

`default_nettype wire

//--- src/lane_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_cfg.svh"

// Input front end of the lane-detection pipeline
// Raw pixels flow from the input queue through the loader into the
// frame buffer and, when inside the window, into the crop queue
module lane_frontend_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_wr_en,
    input  lane_pkg::pixel_t      in_din,
    output logic                  in_full,
    input  logic                  crop_rd_en,
    output lane_pkg::pixel_t      crop_dout,
    output logic                  crop_empty,
    input  lane_pkg::frame_addr_t frame_rd_addr,
    output lane_pkg::pixel_t      frame_rd_data,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  lane_pkg::reg_addr_t   wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic [31:0]           wb_dat_r,
    output logic                  wb_ack
);
    import lane_pkg::*;

    // Input queue to loader
    logic        in_q_rd_en;
    logic        in_q_empty;
    pixel_t      in_q_dout;

    // Loader to crop queue
    logic        crop_wr_en;
    logic        crop_full;
    pixel_t      crop_din;

    // Loader to frame buffer
    logic        fb_wr_en;
    frame_addr_t fb_wr_addr;
    pixel_t      fb_wr_data;

    // Register block and loader handshake
    coord_x_t    start_x;
    coord_x_t    end_x;
    coord_y_t    start_y;
    coord_y_t    end_y;
    logic        busy;
    logic        frame_done;

    pixel_fifo #(
        .DEPTH (`LANE_IN_FIFO_DEPTH)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_q_rd_en),
        .dout  (in_q_dout),
        .empty (in_q_empty)
    );

    image_loader loader (
        .clock      (clock),
        .reset      (reset),
        .in_rd_en   (in_q_rd_en),
        .in_empty   (in_q_empty),
        .in_dout    (in_q_dout),
        .crop_wr_en (crop_wr_en),
        .crop_full  (crop_full),
        .crop_din   (crop_din),
        .fb_wr_en   (fb_wr_en),
        .fb_wr_addr (fb_wr_addr),
        .fb_wr_data (fb_wr_data),
        .start_x    (start_x),
        .end_x      (end_x),
        .start_y    (start_y),
        .end_y      (end_y),
        .busy       (busy),
        .frame_done (frame_done)
    );

    pixel_fifo #(
        .DEPTH (`LANE_CROP_FIFO_DEPTH)
    ) crop_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (crop_wr_en),
        .din   (crop_din),
        .full  (crop_full),
        .rd_en (crop_rd_en),
        .dout  (crop_dout),
        .empty (crop_empty)
    );

    frame_buffer fb (
        .clock   (clock),
        .wr_en   (fb_wr_en),
        .wr_addr (fb_wr_addr),
        .wr_data (fb_wr_data),
        .rd_addr (frame_rd_addr),
        .rd_data (frame_rd_data)
    );

    roi_regs regs (
        .clock      (clock),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .start_x    (start_x),
        .end_x      (end_x),
        .start_y    (start_y),
        .end_y      (end_y),
        .busy       (busy),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

//--- bench/lane_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_cfg.svh"

module lane_frontend_tb;
    import lane_pkg::*;

    localparam int W = `LANE_WIDTH;
    localparam int H = `LANE_HEIGHT;
    localparam int FRAME_PIXELS = W * H;
    // Longest number of cycles any single wait may take
    localparam int TIMEOUT = 400;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_wr_en;
    pixel_t      in_din;
    logic        in_full;
    logic        crop_rd_en;
    pixel_t      crop_dout;
    logic        crop_empty;
    frame_addr_t frame_rd_addr;
    pixel_t      frame_rd_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    reg_addr_t   wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // Current frame and the crop sequence it should produce
    pixel_t      frame_pix [FRAME_PIXELS];
    pixel_t      exp_q [$];
    logic [15:0] lfsr;
    int          ref_sx, ref_ex, ref_sy, ref_ey;
    int          frames_sent;
    int          ack_cycles;
    logic        saw_full;
    logic        timed_out;
    int          checks, errors, tests, failed_tests, test_start_errors;

    lane_frontend_top dut0 (
        .clock(clock), .reset(reset),
        .in_wr_en(in_wr_en), .in_din(in_din), .in_full(in_full),
        .crop_rd_en(crop_rd_en), .crop_dout(crop_dout), .crop_empty(crop_empty),
        .frame_rd_addr(frame_rd_addr), .frame_rd_data(frame_rd_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    always #5 clock = ~clock;

    // Galois form with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Inclusive window test against the bounds the frame was started with
    function automatic bit in_window(input int x, input int y);
        in_window = (x >= ref_sx) && (x <= ref_ex) && (y >= ref_sy) && (y <= ref_ey);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout while %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic next_pixel(output pixel_t p);
        int b;
        p = '0;
        // One LFSR step per pixel bit
        for (b = 0; b < 24; b++) begin
            p    = {p[22:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic wb_read(input reg_addr_t adr, output logic [31:0] data);
        int waited;
        @(posedge clock);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        waited = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
        end while (!wb_ack && waited < TIMEOUT);
        if (!wb_ack) note_timeout("waiting for a Wishbone read ack");
        // Read data is valid together with ack
        data       = wb_dat_r;
        ack_cycles = waited;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t adr, input logic [31:0] data);
        int waited;
        @(posedge clock);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        waited   = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
        end while (!wb_ack && waited < TIMEOUT);
        if (!wb_ack) note_timeout("waiting for a Wishbone write ack");
        ack_cycles = waited;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
    endtask

    task automatic program_window(input int sx, input int ex, input int sy, input int ey);
        wb_write(3'd0, 32'(sx));
        wb_write(3'd1, 32'(ex));
        wb_write(3'd2, 32'(sy));
        wb_write(3'd3, 32'(ey));
    endtask

    task automatic use_window(input int sx, input int ex, input int sy, input int ey);
        ref_sx = sx;
        ref_ex = ex;
        ref_sy = sy;
        ref_ey = ey;
    endtask

    // Fresh random frame plus the in-window pixels in raster order
    task automatic build_frame();
        int a;
        exp_q.delete();
        for (a = 0; a < FRAME_PIXELS; a++) begin
            next_pixel(frame_pix[a]);
            if (in_window(a % W, a / W)) exp_q.push_back(frame_pix[a]);
        end
    endtask

    task automatic feed_frame();
        int i, idle;
        i    = 0;
        idle = 0;
        while (i < FRAME_PIXELS && !timed_out) begin
            @(posedge clock);
            #1;
            // in_full only moves on a clock edge, so it is safe to look at here
            if (!in_full) begin
                in_wr_en = 1'b1;
                in_din   = frame_pix[i];
                i++;
                idle = 0;
            end else begin
                in_wr_en = 1'b0;
                idle++;
                if (idle > TIMEOUT) note_timeout("waiting for in_full to fall");
            end
        end
        @(posedge clock);
        #1;
        in_wr_en = 1'b0;
    endtask

    // Pops and compares every expected crop pixel
    // The pop pauses for stall_len cycles once stall_at pixels have come out
    task automatic drain_crop(input int stall_at, input int stall_len);
        int n, idle, hold;
        n    = 0;
        idle = 0;
        hold = 0;
        while (n < exp_q.size() && !timed_out) begin
            @(posedge clock);
            #1;
            crop_rd_en = 1'b0;
            if (n == stall_at && hold < stall_len) begin
                hold++;
                if (in_full) saw_full = 1'b1;
            end else if (!crop_empty) begin
                check_value("crop_dout", 32'(crop_dout), 32'(exp_q[n]));
                crop_rd_en = 1'b1;
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) note_timeout("waiting for a cropped pixel");
            end
        end
        @(posedge clock);
        #1;
        crop_rd_en = 1'b0;
    endtask

    task automatic wait_frame_count(input int target);
        logic [31:0] d;
        int          tries;
        tries = 0;
        wb_read(3'd4, d);
        while (d != 32'(target) && !timed_out) begin
            tries++;
            if (tries > TIMEOUT) note_timeout("waiting for frame_count to reach the frames sent");
            else wb_read(3'd4, d);
        end
    endtask

    // Moves the window once the loader is mid-frame
    task automatic retarget_when_busy(input int sx, input int ex, input int sy, input int ey);
        logic [31:0] d;
        int          tries;
        tries = 0;
        d     = '0;
        while (d[0] != 1'b1 && !timed_out) begin
            wb_read(3'd5, d);
            tries++;
            if (tries > TIMEOUT) note_timeout("waiting for busy to rise");
        end
        program_window(sx, ex, sy, ey);
        wb_read(3'd5, d);
        check_value("busy", d, 32'd1);
    endtask

    task automatic check_frame_buffer();
        int a;
        for (a = 0; a < FRAME_PIXELS; a++) begin
            @(posedge clock);
            #1;
            frame_rd_addr = frame_addr_t'(a);
            // Registered read, so the word shows up one clock later
            @(posedge clock);
            #1;
            check_value("frame_rd_data", 32'(frame_rd_data), 32'(frame_pix[a]));
        end
    endtask

    task automatic run_frame(input int stall_at, input int stall_len, input bit retarget);
        build_frame();
        fork
            feed_frame();
            drain_crop(stall_at, stall_len);
            begin
                if (retarget) retarget_when_busy(5, 12, 4, 9);
            end
        join
        frames_sent++;
        wait_frame_count(frames_sent);
        // Nothing beyond the expected pixels may be left in the crop queue
        check_value("crop_empty", 32'(crop_empty), 32'd1);
        check_frame_buffer();
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
            failed_tests++;
        end
        test_start_errors = errors;
    endtask

    task automatic test_defaults();
        logic [31:0] d;
        check_value("in_full", 32'(in_full), 32'd0);
        check_value("crop_empty", 32'(crop_empty), 32'd1);
        wb_read(3'd0, d);
        check_value("start_x", d, 32'(`LANE_DEF_START_X));
        check_value("ack_cycles", 32'(ack_cycles), 32'd1);
        wb_read(3'd1, d);
        check_value("end_x", d, 32'(`LANE_DEF_END_X));
        check_value("ack_cycles", 32'(ack_cycles), 32'd1);
        wb_read(3'd2, d);
        check_value("start_y", d, 32'(`LANE_DEF_START_Y));
        wb_read(3'd3, d);
        check_value("end_y", d, 32'(`LANE_DEF_END_Y));
        wb_read(3'd4, d);
        check_value("frame_count", d, 32'd0);
        wb_read(3'd5, d);
        check_value("busy", d, 32'd0);
        check_value("ack_cycles", 32'(ack_cycles), 32'd1);
    endtask

    initial begin
        logic [31:0] d;
        reset         = 1'b1;
        in_wr_en      = 1'b0;
        in_din        = '0;
        crop_rd_en    = 1'b0;
        frame_rd_addr = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        lfsr          = 16'd90;
        frames_sent   = 0;
        saw_full      = 1'b0;
        timed_out     = 1'b0;
        checks        = 0;
        errors        = 0;
        tests         = 0;
        failed_tests  = 0;
        test_start_errors = 0;
        use_window(`LANE_DEF_START_X, `LANE_DEF_END_X, `LANE_DEF_START_Y, `LANE_DEF_END_Y);
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        test_defaults();
        finish_test("register defaults");

        if (!timed_out) run_frame(-1, 0, 1'b0);
        finish_test("full window frame");

        // Columns 3 to 10 and rows 2 to 7 give 48 cropped pixels
        if (!timed_out) begin
            program_window(3, 10, 2, 7);
            use_window(3, 10, 2, 7);
            wb_read(3'd0, d);
            check_value("start_x", d, 32'd3);
            wb_read(3'd1, d);
            check_value("end_x", d, 32'd10);
            wb_read(3'd2, d);
            check_value("start_y", d, 32'd2);
            wb_read(3'd3, d);
            check_value("end_y", d, 32'd7);
            run_frame(-1, 0, 1'b0);
        end
        finish_test("cropped window frame");

        // Long drain stall mid-frame so both queues back up
        if (!timed_out) begin
            saw_full = 1'b0;
            run_frame(10, 60, 1'b0);
            checks++;
            assert (saw_full) else begin
                $display("in_full never rose while the crop drain was stalled");
                errors++;
            end
        end
        finish_test("crop back-pressure");

        // First frame keeps the old window, the second picks up the new one
        if (!timed_out) begin
            run_frame(-1, 0, 1'b1);
            use_window(5, 12, 4, 9);
            if (!timed_out) run_frame(-1, 0, 1'b0);
            wb_read(3'd4, d);
            check_value("frame_count", d, 32'(frames_sent));
        end
        finish_test("window change while busy");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/lane_pkg.sv
src/pixel_fifo.sv
src/image_loader.sv
src/frame_buffer.sv
src/roi_regs.sv
src/lane_frontend_top.sv
bench/lane_frontend_tb.sv

//--- run.sh
#!/bin/sh
# Builds the lane front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f all.f \
    --top-module lane_frontend_tb \
    -o lane_frontend_sim

./obj_dir/lane_frontend_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0
